// File: src/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Cache geometry
`define CACHE_WAYS       4
`define CACHE_SETS       16
`define CACHE_LINE_BYTES 32
`define CACHE_TAG_W      23

// Widths derived from the geometry
`define CACHE_WAY_W      $clog2(`CACHE_WAYS)
`define CACHE_SET_W      $clog2(`CACHE_SETS)
`define CACHE_OFS_W      $clog2(`CACHE_LINE_BYTES)
`define CACHE_LINE_W     (`CACHE_LINE_BYTES * 8)
`define CACHE_WORDS      (`CACHE_LINE_BYTES / 4)

// Tree pseudo-LRU keeps one bit per internal node
`define CACHE_LRU_W      (`CACHE_WAYS - 1)

`endif

// File: src/cache_pkg.sv
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    // Request held between the two pipeline stages
    typedef struct packed {
        logic [31:0]                  addr;
        logic [`CACHE_TAG_W-1:0]      tag;
        logic [`CACHE_SET_W-1:0]      set_no;
        logic [`CACHE_OFS_W-1:0]      offset;
        logic [3:0]                   rmask;
        logic [3:0]                   wmask;
        logic [31:0]                  wdata;
        logic                         busy;
    } stage_reg_t;

    // One cache line, flat or by word
    typedef union packed {
        logic [`CACHE_LINE_W-1:0]          flat;
        logic [`CACHE_WORDS-1:0][31:0]     words;
    } cache_line_u;

    // A nonzero byte enable also writes tag, valid and dirty
    typedef struct packed {
        logic [`CACHE_WAY_W-1:0]      way;
        logic [`CACHE_SET_W-1:0]      set;
        cache_line_u                  data;
        logic [`CACHE_LINE_BYTES-1:0] byte_en;
        logic [`CACHE_TAG_W-1:0]      tag;
        logic                         valid;
        logic                         dirty;
    } array_wr_t;

    typedef enum logic [1:0] {
        miss_idle,
        miss_writeback,
        miss_fetch
    } miss_state_t;

endpackage

`default_nettype wire

// File: src/cache_arrays.sv
`default_nettype none

`include "cache_macros.svh"

module cache_arrays (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [`CACHE_SET_W-1:0]                     rd_set,
    input  cache_pkg::array_wr_t                        wr,
    input  logic                                        lru_wr_en,
    input  logic [`CACHE_SET_W-1:0]                     lru_wr_set,
    input  logic [`CACHE_LRU_W-1:0]                     lru_wr_bits,
    output logic [`CACHE_WAYS-1:0][`CACHE_TAG_W-1:0]    rd_tag,
    output logic [`CACHE_WAYS-1:0]                      rd_valid,
    output logic [`CACHE_WAYS-1:0]                      rd_dirty,
    output cache_pkg::cache_line_u [`CACHE_WAYS-1:0]    rd_data,
    output logic [`CACHE_LRU_W-1:0]                     rd_lru
);

    cache_pkg::cache_line_u      data_mem  [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_TAG_W-1:0]     tag_mem   [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_SETS-1:0]      valid_mem [`CACHE_WAYS];
    logic [`CACHE_SETS-1:0]      dirty_mem [`CACHE_WAYS];
    logic [`CACHE_LRU_W-1:0]     lru_mem   [`CACHE_SETS];

    logic                        wr_en;
    logic [`CACHE_WAYS-1:0]      wr_fwd;
    cache_pkg::cache_line_u      merged;

    assign wr_en = |wr.byte_en;

    always_comb begin
        merged = data_mem[wr.way][wr.set];
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            if (wr.byte_en[b]) begin
                merged.flat[8*b +: 8] = wr.data.flat[8*b +: 8];
            end
        end
    end

    // Same-edge write to the set being read shows up in this read
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            wr_fwd[w] = wr_en && (wr.way == w) && (wr.set == rd_set);
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (wr_fwd[w]) begin
                rd_data[w] <= merged;
                rd_tag[w]  <= wr.tag;
            end else begin
                rd_data[w] <= data_mem[w][rd_set];
                rd_tag[w]  <= tag_mem[w][rd_set];
            end
        end
        if (wr_en) begin
            data_mem[wr.way][wr.set] <= merged;
            tag_mem[wr.way][wr.set]  <= wr.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem <= '{default: '0};
            dirty_mem <= '{default: '0};
            lru_mem   <= '{default: '0};
            rd_valid  <= '0;
            rd_dirty  <= '0;
            rd_lru    <= '0;
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                rd_valid[w] <= wr_fwd[w] ? wr.valid : valid_mem[w][rd_set];
                rd_dirty[w] <= wr_fwd[w] ? wr.dirty : dirty_mem[w][rd_set];
            end
            rd_lru <= (lru_wr_en && lru_wr_set == rd_set) ? lru_wr_bits : lru_mem[rd_set];
            if (wr_en) begin
                valid_mem[wr.way][wr.set] <= wr.valid;
                dirty_mem[wr.way][wr.set] <= wr.dirty;
            end
            if (lru_wr_en) begin
                lru_mem[lru_wr_set] <= lru_wr_bits;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/cache_stage_1.sv
`default_nettype none

`include "cache_macros.svh"

module cache_stage_1 (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [31:0]                 ufp_addr,
    input  logic [3:0]                  ufp_rmask,
    input  logic [3:0]                  ufp_wmask,
    input  logic [31:0]                 ufp_wdata,
    input  logic                        stall_miss,
    input  logic                        hit_write,
    input  logic [`CACHE_WAY_W-1:0]     hit_way,
    input  logic                        fill_valid,
    input  cache_pkg::cache_line_u      fill_line,
    input  logic [`CACHE_LRU_W-1:0]     lru_bits,
    output cache_pkg::stage_reg_t       stage_reg,
    output cache_pkg::array_wr_t        wr,
    output logic [`CACHE_WAY_W-1:0]     victim_way
);

    cache_pkg::stage_reg_t              req_next;
    logic [`CACHE_OFS_W-3:0]            word_idx;

    assign word_idx = stage_reg.offset[`CACHE_OFS_W-1:2];

    // Follow the tree toward the least recently used leaf
    always_comb begin
        if (lru_bits[0]) begin
            victim_way = lru_bits[1] ? 2'd0 : 2'd1;
        end else begin
            victim_way = lru_bits[2] ? 2'd2 : 2'd3;
        end
    end

    always_comb begin
        req_next.addr   = ufp_addr;
        req_next.tag    = ufp_addr[31 -: `CACHE_TAG_W];
        req_next.set_no = ufp_addr[`CACHE_OFS_W +: `CACHE_SET_W];
        req_next.offset = ufp_addr[`CACHE_OFS_W-1:0];
        req_next.rmask  = ufp_rmask;
        req_next.wmask  = ufp_wmask;
        req_next.wdata  = ufp_wdata;
        req_next.busy   = (|ufp_rmask) || (|ufp_wmask);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_reg.busy <= 1'b0;
        end else if (!stall_miss) begin
            if (hit_write) begin
                // Store merges this cycle so the next request waits one cycle
                stage_reg.busy <= 1'b0;
            end else begin
                stage_reg <= req_next;
            end
        end
    end

    // Both write sources target the set of the held request
    always_comb begin
        wr       = '0;
        wr.set   = stage_reg.set_no;
        wr.tag   = stage_reg.tag;
        wr.valid = 1'b1;
        if (fill_valid) begin
            wr.way     = victim_way;
            wr.data    = fill_line;
            wr.byte_en = '1;
            wr.dirty   = 1'b0;
        end else if (hit_write) begin
            wr.way                              = hit_way;
            wr.data.words[word_idx]             = stage_reg.wdata;
            wr.byte_en[{word_idx, 2'b00} +: 4]  = stage_reg.wmask;
            wr.dirty                            = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/cache_stage_2.sv
`default_nettype none

`include "cache_macros.svh"

module cache_stage_2 (
    input  logic                                        clk,
    input  logic                                        rst,
    input  cache_pkg::stage_reg_t                       stage_reg,
    input  logic [`CACHE_WAY_W-1:0]                     victim_way,
    input  logic [`CACHE_WAYS-1:0][`CACHE_TAG_W-1:0]    rd_tag,
    input  logic [`CACHE_WAYS-1:0]                      rd_valid,
    input  logic [`CACHE_WAYS-1:0]                      rd_dirty,
    input  cache_pkg::cache_line_u [`CACHE_WAYS-1:0]    rd_data,
    input  logic [`CACHE_LRU_W-1:0]                     rd_lru,
    input  logic                                        dfp_resp,
    output logic [31:0]                                 ufp_rdata,
    output logic                                        ufp_resp,
    output logic [31:0]                                 dfp_addr,
    output logic                                        dfp_read,
    output logic                                        dfp_write,
    output cache_pkg::cache_line_u                      dfp_wdata,
    output logic                                        stall_miss,
    output logic                                        hit_write,
    output logic [`CACHE_WAY_W-1:0]                     hit_way,
    output logic                                        fill_valid,
    output logic                                        lru_wr_en,
    output logic [`CACHE_LRU_W-1:0]                     lru_wr_bits
);

    localparam int way_w = `CACHE_WAY_W;

    cache_pkg::miss_state_t         state;
    cache_pkg::miss_state_t         state_next;
    logic                           req;
    logic                           hit_any;
    logic                           hit;
    logic                           victim_dirty;

    assign req = stage_reg.busy;

    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (rd_valid[w] && rd_tag[w] == stage_reg.tag) begin
                hit_any = 1'b1;
                hit_way = way_w'(w);
            end
        end
    end

    assign hit          = req && hit_any && (state == cache_pkg::miss_idle);
    assign stall_miss   = req && !hit;
    assign victim_dirty = rd_valid[victim_way] && rd_dirty[victim_way];

    assign ufp_resp  = hit;
    assign ufp_rdata = rd_data[hit_way].words[stage_reg.offset[`CACHE_OFS_W-1:2]];
    assign hit_write = hit && (|stage_reg.wmask);

    // Point the tree nodes on the hit path away from the way just used
    always_comb begin
        lru_wr_en      = hit;
        lru_wr_bits    = rd_lru;
        lru_wr_bits[0] = hit_way[1];
        if (hit_way[1]) begin
            lru_wr_bits[2] = hit_way[0];
        end else begin
            lru_wr_bits[1] = hit_way[0];
        end
    end

    assign dfp_wdata = rd_data[victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::miss_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        dfp_read   = 1'b0;
        dfp_write  = 1'b0;
        fill_valid = 1'b0;
        dfp_addr   = {stage_reg.addr[31:`CACHE_OFS_W], {`CACHE_OFS_W{1'b0}}};
        case (state)
            cache_pkg::miss_idle: begin
                if (req && !hit_any) begin
                    state_next = victim_dirty ? cache_pkg::miss_writeback
                                              : cache_pkg::miss_fetch;
                end
            end
            cache_pkg::miss_writeback: begin
                // Victim goes back to its own address
                dfp_write = 1'b1;
                dfp_addr  = {rd_tag[victim_way], stage_reg.set_no, {`CACHE_OFS_W{1'b0}}};
                if (dfp_resp) begin
                    state_next = cache_pkg::miss_fetch;
                end
            end
            cache_pkg::miss_fetch: begin
                dfp_read = 1'b1;
                if (dfp_resp) begin
                    fill_valid = 1'b1;
                    state_next = cache_pkg::miss_idle;
                end
            end
            default: begin
                state_next = cache_pkg::miss_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/cache_top.sv
`default_nettype none

`include "cache_macros.svh"

module cache_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [31:0]                 ufp_addr,
    input  logic [3:0]                  ufp_rmask,
    input  logic [3:0]                  ufp_wmask,
    input  logic [31:0]                 ufp_wdata,
    output logic [31:0]                 ufp_rdata,
    output logic                        ufp_resp,
    output logic [31:0]                 dfp_addr,
    output logic                        dfp_read,
    output logic                        dfp_write,
    output cache_pkg::cache_line_u      dfp_wdata,
    input  cache_pkg::cache_line_u      dfp_rdata,
    input  logic                        dfp_resp
);

    cache_pkg::stage_reg_t                          stage_reg;
    cache_pkg::array_wr_t                           wr;
    logic [`CACHE_WAY_W-1:0]                        victim_way;
    logic [`CACHE_WAY_W-1:0]                        hit_way;
    logic                                           stall_miss;
    logic                                           hit_write;
    logic                                           fill_valid;
    logic                                           lru_wr_en;
    logic [`CACHE_LRU_W-1:0]                        lru_wr_bits;
    logic [`CACHE_SET_W-1:0]                        rd_set;
    logic [`CACHE_SET_W-1:0]                        lru_wr_set;
    logic [`CACHE_WAYS-1:0][`CACHE_TAG_W-1:0]       rd_tag;
    logic [`CACHE_WAYS-1:0]                         rd_valid;
    logic [`CACHE_WAYS-1:0]                         rd_dirty;
    cache_pkg::cache_line_u [`CACHE_WAYS-1:0]       rd_data;
    logic [`CACHE_LRU_W-1:0]                        rd_lru;

    // During a miss keep reading the held set so stage 2 sees the fill
    assign rd_set     = stall_miss ? stage_reg.set_no : ufp_addr[`CACHE_OFS_W +: `CACHE_SET_W];
    assign lru_wr_set = stage_reg.set_no;

    cache_stage_1 stage_1_i (
        .clk        (clk),
        .rst        (rst),
        .ufp_addr   (ufp_addr),
        .ufp_rmask  (ufp_rmask),
        .ufp_wmask  (ufp_wmask),
        .ufp_wdata  (ufp_wdata),
        .stall_miss (stall_miss),
        .hit_write  (hit_write),
        .hit_way    (hit_way),
        .fill_valid (fill_valid),
        .fill_line  (dfp_rdata),
        .lru_bits   (rd_lru),
        .stage_reg  (stage_reg),
        .wr         (wr),
        .victim_way (victim_way)
    );

    cache_stage_2 stage_2_i (
        .clk         (clk),
        .rst         (rst),
        .stage_reg   (stage_reg),
        .victim_way  (victim_way),
        .rd_tag      (rd_tag),
        .rd_valid    (rd_valid),
        .rd_dirty    (rd_dirty),
        .rd_data     (rd_data),
        .rd_lru      (rd_lru),
        .dfp_resp    (dfp_resp),
        .ufp_rdata   (ufp_rdata),
        .ufp_resp    (ufp_resp),
        .dfp_addr    (dfp_addr),
        .dfp_read    (dfp_read),
        .dfp_write   (dfp_write),
        .dfp_wdata   (dfp_wdata),
        .stall_miss  (stall_miss),
        .hit_write   (hit_write),
        .hit_way     (hit_way),
        .fill_valid  (fill_valid),
        .lru_wr_en   (lru_wr_en),
        .lru_wr_bits (lru_wr_bits)
    );

    cache_arrays arrays_i (
        .clk         (clk),
        .rst         (rst),
        .rd_set      (rd_set),
        .wr          (wr),
        .lru_wr_en   (lru_wr_en),
        .lru_wr_set  (lru_wr_set),
        .lru_wr_bits (lru_wr_bits),
        .rd_tag      (rd_tag),
        .rd_valid    (rd_valid),
        .rd_dirty    (rd_dirty),
        .rd_data     (rd_data),
        .rd_lru      (rd_lru)
    );

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset drops on a falling edge after 16 cycles
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/cache_chk.sv
`default_nettype none

module cache_chk (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  ufp_rmask,
    input  logic [3:0]  ufp_wmask,
    input  logic        ufp_resp,
    input  logic        hit_write,
    input  logic [31:0] dfp_addr,
    input  logic        dfp_read,
    input  logic        dfp_write,
    input  logic        dfp_resp
);

    read_write_excl: assert property (@(posedge clk) disable iff (rst)
        !(dfp_read && dfp_write))
        else $error("dfp_read and dfp_write are high together");

    // Command and address hold until memory answers
    read_held: assert property (@(posedge clk) disable iff (rst)
        dfp_read && !dfp_resp |=> dfp_read && $stable(dfp_addr))
        else $error("dfp read dropped or its address moved before dfp_resp");

    write_held: assert property (@(posedge clk) disable iff (rst)
        dfp_write && !dfp_resp |=> dfp_write && $stable(dfp_addr))
        else $error("dfp write dropped or its address moved before dfp_resp");

    // One cycle per response unless a new request was taken behind it
    resp_single: assert property (@(posedge clk) disable iff (rst)
        ufp_resp && (hit_write || (ufp_rmask == '0 && ufp_wmask == '0)) |=> !ufp_resp)
        else $error("ufp_resp repeated for a request that was already answered");

endmodule

`default_nettype wire

// File: sim/cache_tb.sv
`default_nettype none

`include "cache_macros.svh"

module cache_tb;

    localparam int any_resp     = 0;
    localparam int expect_hit   = 1;
    localparam int expect_fetch = 2;
    localparam int expect_evict = 3;
    localparam int random_rows  = 60;

    typedef struct {
        string       name;
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
        int          kind;
        logic [31:0] wb_addr;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic [31:0]            ufp_addr;
    logic [3:0]             ufp_rmask;
    logic [3:0]             ufp_wmask;
    logic [31:0]            ufp_wdata;
    logic [31:0]            ufp_rdata;
    logic                   ufp_resp;
    logic [31:0]            dfp_addr;
    logic                   dfp_read;
    logic                   dfp_write;
    cache_pkg::cache_line_u dfp_wdata;
    cache_pkg::cache_line_u dfp_rdata;
    logic                   dfp_resp;

    row_t                   rows[$];
    logic [7:0]             shadow [logic [31:0]];
    cache_pkg::cache_line_u mem_lines [logic [31:0]];
    integer                 seed = 32'hb8ed;
    int                     mismatch_count = 0;
    int                     other_count = 0;
    int                     fetch_count = 0;
    int                     wb_count = 0;
    logic [31:0]            last_fetch_addr;
    logic [31:0]            last_wb_addr;
    logic                   after_store;
    string                  row_name;

    clk_gen clk_gen_i (.clk(clk), .rst(rst));

    cache_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_wdata (ufp_wdata),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_wdata (dfp_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    bind cache_top cache_chk chk_i (
        .clk       (clk),
        .rst       (rst),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_resp  (ufp_resp),
        .hit_write (hit_write),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_resp  (dfp_resp)
    );

    // Every address bit takes part in the fill value
    function automatic logic [31:0] init_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9);
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set_no, input int offset);
        return (32'(tag) << (32 - `CACHE_TAG_W)) | (32'(set_no) << `CACHE_OFS_W) | 32'(offset);
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] a);
        return a & ~32'(`CACHE_LINE_BYTES - 1);
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        logic [31:0] base;
        logic [31:0] w;
        int          b;
        base = {a[31:2], 2'b00};
        w    = init_word(base);
        for (b = 0; b < 4; b++) begin
            if (shadow.exists(base + 32'(b))) begin
                w[8*b +: 8] = shadow[base + 32'(b)];
            end
        end
        return w;
    endfunction

    function automatic cache_pkg::cache_line_u shadow_line(input logic [31:0] a);
        cache_pkg::cache_line_u l;
        int                     i;
        for (i = 0; i < `CACHE_WORDS; i++) begin
            l.words[i] = shadow_word(a + 32'(4 * i));
        end
        return l;
    endfunction

    function automatic cache_pkg::cache_line_u memory_line(input logic [31:0] a);
        cache_pkg::cache_line_u l;
        int                     i;
        if (mem_lines.exists(a)) begin
            return mem_lines[a];
        end
        for (i = 0; i < `CACHE_WORDS; i++) begin
            l.words[i] = init_word(a + 32'(4 * i));
        end
        return l;
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_line(input string name, input cache_pkg::cache_line_u expected,
                              input cache_pkg::cache_line_u actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected.flat, actual.flat);
        end
    endtask

    task automatic add_row(input string name, input logic [31:0] addr, input logic [3:0] rmask,
                           input logic [3:0] wmask, input logic [31:0] wdata, input int kind,
                           input logic [31:0] wb_addr);
        row_t r;
        r.name    = name;
        r.addr    = addr;
        r.rmask   = rmask;
        r.wmask   = wmask;
        r.wdata   = wdata;
        r.kind    = kind;
        r.wb_addr = wb_addr;
        rows.push_back(r);
    endtask

    task automatic build_table();
        int         i;
        int         tag;
        int         set_no;
        int         ofs;
        logic [3:0] m;
        add_row("read_miss_fill", make_addr('h100, 1, 'h04), 4'hf, 4'h0, '0, expect_fetch, '0);
        add_row("read_hit_same_line", make_addr('h100, 1, 'h18), 4'hf, 4'h0, '0, expect_hit, '0);
        add_row("write_partial", make_addr('h100, 1, 'h08), 4'h0, 4'b0101, 32'hdead_beef,
                expect_hit, '0);
        add_row("read_partial", make_addr('h100, 1, 'h08), 4'hf, 4'h0, '0, expect_hit, '0);
        // Five dirty tags in set 2 push the oldest back to memory
        for (i = 0; i < 4; i++) begin
            add_row($sformatf("write_fill_%0d", i), make_addr('h200 + i, 2, 'h0c), 4'h0, 4'hf,
                    32'hc0de_0000 + i, expect_fetch, '0);
        end
        add_row("write_evict_dirty", make_addr('h204, 2, 'h0c), 4'h0, 4'hf, 32'hc0de_0004,
                expect_evict, make_addr('h200, 2, 0));
        add_row("reread_written_back", make_addr('h200, 2, 'h0c), 4'hf, 4'h0, '0,
                expect_evict, make_addr('h201, 2, 0));
        // Fill set 3 and touch three ways so the untouched one becomes the victim
        for (i = 0; i < 4; i++) begin
            add_row($sformatf("read_fill_%0d", i), make_addr('h300 + i, 3, 0), 4'hf, 4'h0, '0,
                    expect_fetch, '0);
        end
        for (i = 0; i < 3; i++) begin
            add_row($sformatf("touch_%0d", i), make_addr('h300 + i, 3, 'h10), 4'hf, 4'h0, '0,
                    expect_hit, '0);
        end
        add_row("read_new_tag", make_addr('h304, 3, 0), 4'hf, 4'h0, '0, expect_fetch, '0);
        add_row("read_kept_line", make_addr('h302, 3, 'h04), 4'hf, 4'h0, '0, expect_hit, '0);
        add_row("reread_victim", make_addr('h303, 3, 'h1c), 4'hf, 4'h0, '0, expect_fetch, '0);
        for (i = 0; i < random_rows; i++) begin
            tag    = 'h400 + int'($unsigned($random(seed)) % 6);
            set_no = 4 + int'($unsigned($random(seed)) % 3);
            ofs    = 4 * int'($unsigned($random(seed)) % 8);
            m      = 4'($random(seed));
            if (m == 4'h0) begin
                m = 4'hf;
            end
            if (($random(seed) & 1) != 0) begin
                add_row($sformatf("random_read_%0d", i), make_addr(tag, set_no, ofs), 4'hf,
                        4'h0, '0, any_resp, '0);
            end else begin
                add_row($sformatf("random_write_%0d", i), make_addr(tag, set_no, ofs), 4'h0,
                        m, $random(seed), any_resp, '0);
            end
        end
    endtask

    task automatic apply_row(input row_t r);
        int cycles;
        int expected_cycles;
        int fetch_before;
        int wb_before;
        int b;
        fetch_before = fetch_count;
        wb_before    = wb_count;
        cycles       = 0;
        // A store that merged just before delays acceptance by one cycle
        expected_cycles = after_store ? 2 : 1;
        row_name     = r.name;
        ufp_addr     = r.addr;
        ufp_rmask    = r.rmask;
        ufp_wmask    = r.wmask;
        ufp_wdata    = r.wdata;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ufp_resp);
        if (r.rmask != 4'h0) begin
            check_word(r.name, shadow_word(r.addr), ufp_rdata);
        end
        for (b = 0; b < 4; b++) begin
            if (r.wmask[b]) begin
                shadow[{r.addr[31:2], 2'b00} + 32'(b)] = r.wdata[8*b +: 8];
            end
        end
        if (r.kind == expect_hit) begin
            if (fetch_count != fetch_before || wb_count != wb_before ||
                cycles != expected_cycles) begin
                other_count++;
                $display("ERROR %s: expected a hit but it went to memory or answered off time",
                         r.name);
            end
        end else if (r.kind != any_resp) begin
            if (fetch_count != fetch_before + 1) begin
                other_count++;
                $display("ERROR %s: expected exactly one line fetch", r.name);
            end
            if (wb_count != wb_before + ((r.kind == expect_evict) ? 1 : 0)) begin
                other_count++;
                $display("ERROR %s: wrong number of writebacks", r.name);
            end
            check_word({r.name, " fetch address"}, line_of(r.addr), last_fetch_addr);
            if (r.kind == expect_evict) begin
                check_word({r.name, " writeback address"}, r.wb_addr, last_wb_addr);
            end
        end
        after_store = (r.wmask != 4'h0);
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // Line memory that answers after a random delay
    initial begin
        int          delay;
        logic [31:0] addr;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(negedge clk);
            dfp_resp = 1'b0;
            if (!rst && (dfp_read || dfp_write)) begin
                addr  = dfp_addr;
                delay = int'($unsigned($random(seed)) % 5);
                repeat (delay) @(negedge clk);
                if (dfp_write) begin
                    check_line($sformatf("%s writeback of line %h", row_name, addr),
                               shadow_line(addr), dfp_wdata);
                    mem_lines[addr] = dfp_wdata;
                    last_wb_addr    = addr;
                    wb_count++;
                end else begin
                    dfp_rdata       = memory_line(addr);
                    last_fetch_addr = addr;
                    fetch_count++;
                end
                dfp_resp = 1'b1;
            end
        end
    end

    initial begin
        int limit;
        @(negedge clk);
        limit = rows.size() * 200 + 16;
        repeat (limit) @(posedge clk);
        other_count++;
        $display("ERROR the run did not finish within %0d cycles", limit);
        finish_run();
    end

    initial begin
        ufp_addr    = '0;
        ufp_rmask   = '0;
        ufp_wmask   = '0;
        ufp_wdata   = '0;
        after_store = 1'b0;
        row_name    = "";
        build_table();
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        ufp_rmask = '0;
        ufp_wmask = '0;
        repeat (4) @(negedge clk);
        finish_run();
    end

endmodule

`default_nettype wire

// File: pipe_cache.f
+incdir+src
src/cache_pkg.sv
src/cache_arrays.sv
src/cache_stage_1.sv
src/cache_stage_2.sv
src/cache_top.sv
sim/clk_gen.sv
sim/cache_chk.sv
sim/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
    -f pipe_cache.f -o cache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi
